/* activity_leds.sv */
`timescale 1ns/10ps

module activity_leds (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              bus_ack,
    input  logic                              bus_we,
    input  logic [spirw_pkg::data_width-1:0]  bus_dat_w,
    output logic [7:0]                        led
);

    logic [1:0] lit;     // [0] read, [1] write
    logic [5:0] last_hi; // top bits of last written byte

    // one stretcher per direction, index matches we
    for (genvar i = 0; i < 2; i++) begin : g_stretch
        logic [spirw_pkg::led_cnt_bits-1:0] cnt;

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                cnt <= '0;
            end else if (bus_ack && (bus_we == 1'(i))) begin
                cnt <= spirw_pkg::led_cnt_bits'(spirw_pkg::led_stretch_cycles); // retrigger
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end

        assign lit[i] = (cnt != '0);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_hi <= '0;                    // dark until first write
        end else if (bus_ack && bus_we) begin
            last_hi <= bus_dat_w[spirw_pkg::data_width-1:spirw_pkg::data_width-6];
        end
    end

    assign led = {last_hi, lit};

endmodule

/* build.f */
spirw_pkg.sv
wb_if.sv
spirw_slave.sv
wb_byte_ram.sv
activity_leds.sv
top_spirw_ram.sv
tb_top_spirw_ram.sv

/* run_sim.sh */
#!/bin/sh
# compile with verilator, run, and take the verdict from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f build.f --top-module tb_top_spirw_ram \
    -o tb_sim > sim.log 2>&1 &&
./obj_dir/tb_sim >> sim.log 2>&1 ||
{ cat sim.log; echo "build or run error"; exit 1; }
cat sim.log
grep -q 'Test failures found' sim.log && exit 1
grep -q 'All tests passed!' sim.log || exit 1
exit 0

/* spirw_pkg.sv */
package spirw_pkg;

    localparam int addr_width = 16;          // spi address and wishbone adr
    localparam int data_width = 8;           // byte wide data path
    localparam int ram_addr_bits = 10;       // ram decodes low bits only, 1k wrap
    localparam int led_stretch_cycles = 4096; // led on-time after last ack
    localparam int sync_stages = 2;          // input synchronizer depth

    // counter width big enough to hold led_stretch_cycles itself
    localparam int led_cnt_bits = $clog2(led_stretch_cycles + 1);

    // first byte of every transaction
    typedef enum logic [7:0] {
        cmd_write = 8'h00,                   // host -> memory
        cmd_read  = 8'h01                    // memory -> host, one dummy byte first
    } spi_cmd_e;

    // transaction phase, advanced once per received byte
    typedef enum logic [2:0] {
        st_cmd,                              // waiting for opcode
        st_addr_hi,                          // address msb
        st_addr_lo,                          // address lsb
        st_dummy,                            // read turnaround byte
        st_data,                             // streaming data bytes
        st_ignore                            // bad opcode, sit out until csn rises
    } spi_state_e;

endpackage

/* spirw_slave.sv */
`timescale 1ns/10ps

module spirw_slave (
    input  logic clk,
    input  logic rst_n,
    input  logic spi_csn,
    input  logic spi_sclk,
    input  logic spi_mosi,
    output logic spi_miso,
    wb_if.master bus
);

    logic [spirw_pkg::sync_stages-1:0][2:0]      sync_q;    // {csn, sclk, mosi} per stage
    logic                                        csn_s;
    logic                                        sclk_s;
    logic                                        mosi_s;
    logic                                        sclk_d;    // previous sclk for edge detect
    logic                                        sclk_rise;
    logic                                        sclk_fall;
    logic                                        byte_done; // 8th rising edge of a byte
    logic [$clog2(spirw_pkg::data_width)-1:0]    bit_cnt;
    logic [spirw_pkg::data_width-2:0]            rx_sh;     // first 7 bits of current byte
    logic [spirw_pkg::data_width-1:0]            rx_byte;   // incl. bit on this edge
    logic [spirw_pkg::addr_width-1:0]           addr;      // auto-incrementing pointer
    logic [spirw_pkg::data_width-1:0]            tx_next;   // prefetched read byte
    logic [spirw_pkg::data_width-1:0]            tx_sh;     // miso shifter, msb out
    logic                                        is_read;
    logic                                        start_rd;
    logic                                        start_wr;
    spirw_pkg::spi_state_e                       state;
    spirw_pkg::spi_cmd_e                         cmd;

    // async pins into clk domain
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q <= {spirw_pkg::sync_stages{3'b100}}; // csn idle high, sclk low
            sclk_d <= 1'b0;
        end else begin
            sync_q <= {sync_q[spirw_pkg::sync_stages-2:0], {spi_csn, spi_sclk, spi_mosi}};
            sclk_d <= sclk_s;
        end
    end

    assign csn_s  = sync_q[spirw_pkg::sync_stages-1][2];
    assign sclk_s = sync_q[spirw_pkg::sync_stages-1][1];
    assign mosi_s = sync_q[spirw_pkg::sync_stages-1][0];

    assign sclk_rise = sclk_s & ~sclk_d;
    assign sclk_fall = ~sclk_s & sclk_d;
    assign byte_done = sclk_rise & (&bit_cnt) & ~csn_s;
    assign rx_byte   = {rx_sh, mosi_s}; // mode 0, sample on rise

    assign is_read  = (cmd == spirw_pkg::cmd_read);
    // read slot opens after dummy and after each data byte
    assign start_rd = byte_done & ((state == spirw_pkg::st_dummy) ||
                                   (state == spirw_pkg::st_data && is_read));
    assign start_wr = byte_done & (state == spirw_pkg::st_data) & ~is_read;

    // phase FSM and wishbone handshake
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt <= '0;
            state   <= spirw_pkg::st_cmd;
            cmd     <= spirw_pkg::cmd_write;
            bus.cyc <= 1'b0;
            bus.stb <= 1'b0;
        end else begin
            if (csn_s) begin
                bit_cnt <= '0;                // drop partial byte
                state   <= spirw_pkg::st_cmd;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 1'b1;    // wraps to 0 after 8th bit
                if (byte_done) begin
                    case (state)
                        spirw_pkg::st_cmd: begin
                            case (rx_byte)
                                spirw_pkg::cmd_write,
                                spirw_pkg::cmd_read: begin
                                    cmd   <= spirw_pkg::spi_cmd_e'(rx_byte);
                                    state <= spirw_pkg::st_addr_hi;
                                end
                                default: begin
                                    state <= spirw_pkg::st_ignore; // unknown opcode
                                end
                            endcase
                        end
                        spirw_pkg::st_addr_hi: begin
                            state <= spirw_pkg::st_addr_lo;
                        end
                        spirw_pkg::st_addr_lo: begin
                            state <= is_read ? spirw_pkg::st_dummy : spirw_pkg::st_data;
                        end
                        spirw_pkg::st_dummy: begin
                            state <= spirw_pkg::st_data;
                        end
                        default: begin
                            state <= state; // data and ignore hold until csn
                        end
                    endcase
                end
            end
            // drop in the cycle after ack, new cycle only when idle
            if (bus.cyc && bus.ack) begin
                bus.cyc <= 1'b0;
                bus.stb <= 1'b0;
            end else if (start_rd || start_wr) begin
                bus.cyc <= 1'b1;
                bus.stb <= 1'b1;
            end
        end
    end

    // datapath regs
    always_ff @(posedge clk) begin
        if (sclk_rise) begin
            rx_sh <= rx_byte[spirw_pkg::data_width-2:0];
        end
        if (byte_done && state == spirw_pkg::st_addr_hi) begin
            addr[spirw_pkg::addr_width-1:8] <= rx_byte;
        end
        if (byte_done && state == spirw_pkg::st_addr_lo) begin
            addr[7:0] <= rx_byte;
        end
        if (start_rd || start_wr) begin
            bus.we    <= start_wr;
            bus.dat_w <= rx_byte;             // don't care on reads
        end
        if (bus.cyc && bus.ack) begin
            addr <= addr + 1'b1;              // step after every byte
            if (!bus.we) begin
                tx_next <= bus.dat_r;
            end
        end
    end

    assign bus.adr = addr; // stable, only steps on ack

    // miso shifter, moves on falling edges only
    always_ff @(posedge clk) begin
        if (!rst_n || csn_s) begin
            tx_sh <= '0;                      // miso low outside read data
        end else if (sclk_fall && state == spirw_pkg::st_data && is_read) begin
            if (bit_cnt == '0) begin
                tx_sh <= tx_next;             // byte boundary, msb goes out
            end else begin
                tx_sh <= {tx_sh[spirw_pkg::data_width-2:0], 1'b0};
            end
        end
    end

    assign spi_miso = tx_sh[spirw_pkg::data_width-1];

endmodule

/* tb_top_spirw_ram.sv */
`timescale 1ns/10ps

module tb_top_spirw_ram;

    localparam int half_clks = 4;                    // sclk half-period in clk cycles
    localparam int mem_size = 1 << spirw_pkg::ram_addr_bits;
    localparam longint watchdog_ns = 3_000_000;      // ~1.5 ms of spi traffic and led idle

    logic       clk;
    logic       rst_n;
    logic       spi_csn;
    logic       spi_sclk;
    logic       spi_mosi;
    logic       spi_miso;
    logic [7:0] led;

    logic [7:0] model [0:mem_size-1];                // expected ram contents
    logic [7:0] wr_buf [0:15];                       // burst payload
    int         error_cnt;

    top_spirw_ram dut (
        .clk(clk),
        .rst_n(rst_n),
        .spi_csn(spi_csn),
        .spi_sclk(spi_sclk),
        .spi_mosi(spi_mosi),
        .spi_miso(spi_miso),
        .led(led)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                      // 100 ns period
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: run did not finish within %0d ns", watchdog_ns);
        $display("errors: %0d", error_cnt);
        $display("Test failures found");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [7:0] got,
                                   input logic [7:0] exp);
        $display("MISMATCH at %0t: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
        error_cnt++;
    endtask

    task automatic wait_clks(input int n);
        repeat (n) @(posedge clk);
        #10;                                         // drive point after the edge
    endtask

    // 16 bit pointer but the ram decodes only the low bits
    function automatic int ram_index(input logic [15:0] addr, input int offset);
        logic [15:0] a;
        a = addr + 16'(offset);
        return int'(a[spirw_pkg::ram_addr_bits-1:0]);
    endfunction

    // mode 0 where mosi changes while sclk is low and both sides sample on the rise
    task automatic spi_shift(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
        rx = '0;
        for (int i = 7; i > 7 - nbits; i--) begin
            spi_mosi = tx[i];
            wait_clks(half_clks);
            rx[i] = spi_miso;                        // settled since the last fall
            spi_sclk = 1'b1;
            wait_clks(half_clks);
            spi_sclk = 1'b0;
        end
    endtask

    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        spi_shift(tx, 8, rx);
    endtask

    task automatic select_slave();
        spi_csn = 1'b0;
        wait_clks(half_clks);
    endtask

    task automatic release_slave();
        wait_clks(half_clks);                        // last bus cycle drains
        spi_csn = 1'b1;
        wait_clks(2 * half_clks);                    // csn high seen by the slave
    endtask

    task automatic send_header(input logic [7:0] op, input logic [15:0] addr);
        logic [7:0] rx;
        spi_byte(op, rx);
        spi_byte(addr[15:8], rx);                    // msb first
        spi_byte(addr[7:0], rx);
    endtask

    task automatic spi_write_burst(input logic [15:0] addr, input int n);
        logic [7:0] rx;
        select_slave();
        send_header(spirw_pkg::cmd_write, addr);
        for (int i = 0; i < n; i++) begin
            spi_byte(wr_buf[i], rx);
            model[ram_index(addr, i)] = wr_buf[i];
        end
        release_slave();
    endtask

    task automatic spi_read_burst(input logic [15:0] addr, input int n);
        logic [7:0] rx;
        select_slave();
        send_header(spirw_pkg::cmd_read, addr);
        spi_byte(8'h00, rx);                         // dummy byte starts the first fetch
        for (int i = 0; i < n; i++) begin
            spi_byte(8'h00, rx);
            if (rx !== model[ram_index(addr, i)]) begin
                report_mismatch($sformatf("spi_miso byte %0d from 0x%04h", i, addr), rx,
                                model[ram_index(addr, i)]);
            end
        end
        release_slave();
    endtask

    task automatic fill_random(input int n);
        for (int i = 0; i < n; i++) begin
            wr_buf[i] = 8'($urandom());
        end
    endtask

    task automatic test_single_rw();
        fill_random(1);
        spi_write_burst(16'h0045, 1);
        spi_read_burst(16'h0045, 1);
    endtask

    task automatic test_burst_rw();
        fill_random(16);
        spi_write_burst(16'h0120, 16);               // address steps after each byte
        spi_read_burst(16'h0120, 16);
    endtask

    task automatic test_alias();
        fill_random(1);
        spi_write_burst(16'h0003, 1);
        wr_buf[0] = ~wr_buf[0];                      // make the alias write visible
        spi_write_burst(16'h0403, 1);
        spi_read_burst(16'h0003, 1);
    endtask

    task automatic test_abort();
        logic [7:0] rx;
        fill_random(1);
        spi_write_burst(16'h0200, 1);
        select_slave();
        send_header(spirw_pkg::cmd_write, 16'h0200);
        spi_shift(~wr_buf[0], 5, rx);                // csn rises mid byte
        release_slave();
        spi_read_burst(16'h0200, 1);                 // old value expected
    endtask

    task automatic test_bad_opcode();
        logic [7:0] seq [0:4];
        logic [7:0] rx;
        fill_random(1);
        spi_write_burst(16'h0311, 1);
        seq[0] = 8'h5a;
        seq[1] = 8'h03;
        seq[2] = 8'h11;
        seq[3] = ~wr_buf[0];
        seq[4] = 8'hff;
        select_slave();
        for (int i = 0; i < 5; i++) begin
            spi_byte(seq[i], rx);
            if (rx !== 8'h00) begin
                report_mismatch($sformatf("spi_miso ignored byte %0d", i), rx, 8'h00);
            end
        end
        release_slave();
        spi_read_burst(16'h0311, 1);
    endtask

    task automatic test_leds();
        logic [5:0] hi;
        fill_random(1);
        hi = wr_buf[0][7:2];
        spi_write_burst(16'h0077, 1);
        if (led[7:2] !== hi) report_mismatch("led[7:2]", 8'(led[7:2]), 8'(hi));
        wait_clks(2 * spirw_pkg::led_stretch_cycles); // both stretchers run out
        if (led[1:0] !== 2'b00) report_mismatch("led[1:0]", 8'(led[1:0]), 8'h00);
        if (led[7:2] !== hi) report_mismatch("led[7:2]", 8'(led[7:2]), 8'(hi));
        spi_read_burst(16'h0077, 1);
        if (led[0] !== 1'b1) report_mismatch("led[0]", 8'(led[0]), 8'h01);
        if (led[1] !== 1'b0) report_mismatch("led[1]", 8'(led[1]), 8'h00);
        wr_buf[0] = ~wr_buf[0];                      // every top bit flips
        hi = wr_buf[0][7:2];
        spi_write_burst(16'h0078, 1);                // write led starts from dark
        if (led[1] !== 1'b1) report_mismatch("led[1]", 8'(led[1]), 8'h01);
        if (led[7:2] !== hi) report_mismatch("led[7:2]", 8'(led[7:2]), 8'(hi));
    endtask

    initial begin
        error_cnt = 0;
        void'($urandom(32'hd19c));
        rst_n    = 1'b0;
        spi_csn  = 1'b1;                             // idle bus
        spi_sclk = 1'b0;
        spi_mosi = 1'b0;
        wait_clks(8);
        rst_n = 1'b1;
        wait_clks(4);
        if (spi_miso !== 1'b0) report_mismatch("spi_miso", 8'(spi_miso), 8'h00);
        if (led !== 8'h00) report_mismatch("led", led, 8'h00);
        test_single_rw();
        test_burst_rw();
        test_alias();
        test_abort();
        test_bad_opcode();
        test_leds();
        $display("errors: %0d", error_cnt);
        if (error_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* top_spirw_ram.sv */
`timescale 1ns/10ps

module top_spirw_ram (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       spi_csn,
    input  logic       spi_sclk,
    input  logic       spi_mosi,
    output logic       spi_miso,
    output logic [7:0] led
);

    wb_if wb ();                              // slave to ram

    spirw_slave
    spirw_slave_inst
    (
        .clk(clk),
        .rst_n(rst_n),
        .spi_csn(spi_csn),
        .spi_sclk(spi_sclk),
        .spi_mosi(spi_mosi),
        .spi_miso(spi_miso),              // 0 outside read data
        .bus(wb.master)
    );

    wb_byte_ram
    wb_byte_ram_inst
    (
        .clk(clk),
        .rst_n(rst_n),
        .bus(wb.slave)
    );

    // taps the bus as plain wires
    activity_leds
    activity_leds_inst
    (
        .clk(clk),
        .rst_n(rst_n),
        .bus_ack(wb.ack),
        .bus_we(wb.we),
        .bus_dat_w(wb.dat_w),
        .led(led)
    );

endmodule

/* wb_byte_ram.sv */
`timescale 1ns/10ps

// stand-in for the sdram, 1k bytes with one wait state
module wb_byte_ram (
    input  logic clk,
    input  logic rst_n,
    wb_if.slave  bus
);

    logic [spirw_pkg::data_width-1:0]    mem [0:(1 << spirw_pkg::ram_addr_bits)-1];
    logic [spirw_pkg::ram_addr_bits-1:0] word_adr;
    logic                                req;

    assign word_adr = bus.adr[spirw_pkg::ram_addr_bits-1:0]; // upper bits alias
    assign req      = bus.cyc & bus.stb & ~bus.ack;          // not yet acked

    // ack one cycle after request, low again next cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= req;                   // ~ack term blocks a second ack
        end
    end

    // array access on the same edge that raises ack
    always_ff @(posedge clk) begin
        if (req) begin
            if (bus.we) begin
                mem[word_adr] <= bus.dat_w;
            end
            bus.dat_r <= mem[word_adr];       // read before write, valid with ack
        end
    end

endmodule

/* wb_if.sv */
`timescale 1ns/10ps

// wishbone classic, single master single slave
interface wb_if;

    logic                                cyc;   // cycle in progress
    logic                                stb;   // strobe, same as cyc here
    logic                                we;    // 1 write, 0 read
    logic [spirw_pkg::addr_width-1:0]    adr;   // byte address
    logic [spirw_pkg::data_width-1:0]    dat_w; // master to slave
    logic [spirw_pkg::data_width-1:0]    dat_r; // slave to master, valid with ack
    logic                                ack;   // single cycle terminate

    modport master (
        output cyc,
        output stb,
        output we,
        output adr,
        output dat_w,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  adr,
        input  dat_w,
        output dat_r,
        output ack
    );

endinterface
